//--- vlog.f
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_pc_control.sv
rv_core.sv
tb_rv_mem.sv
tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILES     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_rv_core.sv
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam logic [31:0] exit_addr = 32'h1000;
    localparam logic [31:0] data_base = 32'h400;
    localparam logic [6:0]  opc_r     = 7'b0110011;
    localparam logic [6:0]  opc_i     = 7'b0010011;

    // register op table: add sub and or xor sll srl sra slt sltu
    localparam logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5, 3'd5,
                                         3'd2, 3'd3};
    localparam logic [9:0] r_alt     = 10'b0010000010;
    // addi andi ori xori slti sltiu slli srli srai
    localparam logic [2:0] i_f3 [9]  = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5,
                                         3'd5};
    localparam logic [8:0] i_alt     = 9'b100000000;

    logic      clk;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_data;
    logic      dmem_valid;
    dmem_req_t dmem_req;
    logic      dmem_ready;
    word_t     dmem_rdata;
    logic      exit_o;
    word_t     gp;

    logic [31:0] lfsr_state;
    logic [31:0] pc;
    logic [31:0] exp_gp;
    int          soff;
    int          errors;
    int          checks;
    int          n_exp;
    int          xfer_idx;
    string       exp_name [0:255];
    logic        exp_we   [0:255];
    logic [31:0] exp_addr [0:255];
    logic [31:0] exp_data [0:255];

    rv_core #(
        .exit_addr(exit_addr),
        .reset_pc (32'h0)
    ) i_rv_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .dmem_valid_o(dmem_valid),
        .dmem_req_o  (dmem_req),
        .dmem_ready_i(dmem_ready),
        .dmem_rdata_i(dmem_rdata),
        .exit_o      (exit_o),
        .gp_o        (gp)
    );

    tb_rv_mem i_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr_i (imem_addr),
        .imem_data_o (imem_data),
        .dmem_valid_i(dmem_valid),
        .dmem_req_i  (dmem_req),
        .dmem_ready_o(dmem_ready),
        .dmem_rdata_o(dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
    endtask

    // rv32i semantics, alt is instruction bit 30
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    alu_ref = alt ? a - b : a + b;
            3'd1:    alu_ref = a << b[4:0];
            3'd2:    alu_ref = {31'b0, $signed(a) < $signed(b)};
            3'd3:    alu_ref = {31'b0, a < b};
            3'd4:    alu_ref = a ^ b;
            3'd5: begin
                if (alt) begin
                    alu_ref = $signed(a) >>> b[4:0];
                end else begin
                    alu_ref = a >> b[4:0];
                end
            end
            3'd6:    alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        i_mem.imem[pc[12:2]] = w;
        pc                   = pc + 32'd4;
    endtask

    task automatic expect_xfer(input string name, input logic we, input logic [31:0] addr,
                               input logic [31:0] data);
        exp_name[n_exp] = name;
        exp_we[n_exp]   = we;
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    // sw rs2 to the next free slot above x10
    task automatic store_check(input string name, input logic [4:0] rs2,
                               input logic [31:0] value);
        emit(enc_s(12'(soff), rs2, 5'd10));
        expect_xfer(name, 1'b1, data_base + 32'(soff), value);
        soff += 4;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        emit(enc_u(hi[19:0], rd, 7'b0110111));
        emit(enc_i(v[11:0], rd, 3'd0, rd, opc_i));
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] t;
        logic [31:0] p;
        logic [11:0] iw;
        int          n;
        int          off1;
        pc   = '0;
        soff = 0;
        emit(enc_i(12'h400, 5'd0, 3'd0, 5'd10, opc_i));
        for (int r = 0; r < 4; r++) begin
            take_bits(32, a);
            take_bits(32, b);
            load_const(5'd5, a);
            load_const(5'd6, b);
            for (int k = 0; k < 10; k++) begin
                emit(enc_r(r_alt[k] ? 7'h20 : 7'h00, 5'd6, 5'd5, r_f3[k], 5'd7, opc_r));
                store_check("alu reg", 5'd7, alu_ref(r_f3[k], r_alt[k], a, b));
            end
            take_bits(12, t);
            for (int k = 0; k < 9; k++) begin
                if (i_f3[k] == 3'd1 || i_f3[k] == 3'd5) begin
                    iw = {i_alt[k] ? 7'h20 : 7'h00, t[4:0]};
                    b  = {27'b0, t[4:0]};
                end else begin
                    iw = t[11:0];
                    b  = {{20{t[11]}}, t[11:0]};
                end
                emit(enc_i(iw, 5'd5, i_f3[k], 5'd7, opc_i));
                store_check("alu imm", 5'd7, alu_ref(i_f3[k], i_alt[k], a, b));
            end
            take_bits(20, t);
            emit(enc_u(t[19:0], 5'd7, 7'b0110111));
            store_check("lui", 5'd7, {t[19:0], 12'h0});
            take_bits(20, t);
            p = pc;
            emit(enc_u(t[19:0], 5'd7, 7'b0010111));
            store_check("auipc", 5'd7, p + {t[19:0], 12'h0});
        end

        // countdown loop summing into gp
        take_bits(2, t);
        n = int'(t[1:0]) + 3;
        load_const(5'd8, 32'(n));
        emit(enc_r(7'h00, 5'd8, 5'd3, 3'd0, 5'd3, opc_r));
        emit(enc_i(12'hfff, 5'd8, 3'd0, 5'd8, opc_i));
        emit(enc_b(13'h1ff8, 5'd0, 5'd8, 3'b001)); // bne back two words
        exp_gp = 32'(n * (n + 1) / 2 + 7);
        load_const(5'd9, 32'd1);
        emit(enc_b(13'd8, 5'd9, 5'd0, 3'b100)); // blt taken
        emit(enc_i(12'd100, 5'd3, 3'd0, 5'd3, opc_i));
        emit(enc_b(13'd8, 5'd9, 5'd0, 3'b111)); // bgeu falls through
        emit(enc_i(12'd7, 5'd3, 3'd0, 5'd3, opc_i));

        p = pc;
        emit(enc_j(21'd8, 5'd1));
        emit(enc_i(12'd1000, 5'd3, 3'd0, 5'd3, opc_i));
        store_check("jal link", 5'd1, p + 32'd4);
        p = pc;
        emit(enc_u(20'h0, 5'd11, 7'b0010111));
        emit(enc_i(12'd12, 5'd11, 3'd0, 5'd1, 7'b1100111));
        emit(enc_i(12'd1000, 5'd3, 3'd0, 5'd3, opc_i));
        store_check("jalr link", 5'd1, p + 32'd8);

        for (int k = 0; k < 6; k++) begin
            take_bits(32, a);
            load_const(5'd5, a);
            off1 = soff;
            store_check("mem store", 5'd5, a);
            emit(enc_i(12'(off1), 5'd10, 3'b010, 5'd6, 7'b0000011));
            expect_xfer("mem load", 1'b0, data_base + 32'(off1), a);
            store_check("mem copy", 5'd6, a);
        end

        emit(enc_i(12'd123, 5'd0, 3'd0, 5'd0, opc_i));
        store_check("x0", 5'd0, 32'h0);
        emit(enc_j(21'(exit_addr - pc), 5'd0));
    endtask

    // all outputs settled half a cycle after the edge
    always @(negedge clk) begin
        logic [31:0] actual;
        if (!rst_n) begin
            checks++;
            assert (!dmem_valid && !exit_o) else begin
                errors++;
                $display("data request or exit raised during reset");
            end
        end else begin
            checks++;
            assert (exit_o == (imem_addr == exit_addr)) else begin
                errors++;
                $display("error exit flag: expected %b actual %b",
                         imem_addr == exit_addr, exit_o);
            end
            if (dmem_valid && dmem_ready) begin
                if (xfer_idx >= n_exp) begin
                    errors++;
                    $display("unexpected data transfer at address %h", dmem_req.addr);
                end else begin
                    actual = dmem_req.we ? dmem_req.wdata : dmem_rdata;
                    checks++;
                    assert (dmem_req.we == exp_we[xfer_idx]
                            && dmem_req.addr == exp_addr[xfer_idx]) else begin
                        errors++;
                        $display("error %s address: expected %h actual %h",
                                 exp_name[xfer_idx], exp_addr[xfer_idx], dmem_req.addr);
                    end
                    checks++;
                    assert (actual == exp_data[xfer_idx]) else begin
                        errors++;
                        $display("error %s data: expected %h actual %h",
                                 exp_name[xfer_idx], exp_data[xfer_idx], actual);
                    end
                end
                xfer_idx++;
            end
        end
    end

    assert property (@(posedge clk) $rose(rst_n) |-> !dmem_valid && !exit_o)
        else begin
            errors++;
            $display("data request or exit raised right after reset");
        end

    assert property (@(posedge clk) disable iff (!rst_n) exit_o |-> !dmem_valid)
        else begin
            errors++;
            $display("data request issued after exit");
        end

    assert property (@(posedge clk) disable iff (!rst_n) exit_o |=> exit_o)
        else begin
            errors++;
            $display("exit flag dropped after it was raised");
        end

    initial begin
        int cycles;
        rst_n      = 1'b0;
        lfsr_state = 32'hc01b;
        errors     = 0;
        checks     = 0;
        n_exp      = 0;
        xfer_idx   = 0;
        build_program();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!exit_o && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (!exit_o) begin
            $display("timeout: the core never reached the exit address");
            $display("Test failed");
            $finish;
        end
        repeat (20) @(posedge clk); // watch the parked core for a while
        @(negedge clk);
        checks++;
        assert (gp == exp_gp) else begin
            errors++;
            $display("error branch sum: expected %h actual %h", exp_gp, gp);
        end
        checks++;
        if (xfer_idx != n_exp) begin
            errors++;
            $display("only %0d of %0d expected data transfers happened", xfer_idx, n_exp);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_rv_mem.sv
`default_nettype none

module tb_rv_mem (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     imem_addr_i,
    output rv_pkg::word_t     imem_data_o,
    input  logic              dmem_valid_i,
    input  rv_pkg::dmem_req_t dmem_req_i,
    output logic              dmem_ready_o,
    output rv_pkg::word_t     dmem_rdata_o
);
    import rv_pkg::*;

    bit [31:0]   imem [0:2047]; // filled by the program builder
    word_t       dmem [0:1023];
    logic [31:0] lfsr;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        logic [31:0] addr;
        for (int k = 0; k < 1024; k++) begin
            addr    = 32'(k) << 2;
            dmem[k] = 32'hdead_0000 ^ (addr * 32'h9e37_79b1); // whole address hashed
        end
        lfsr         = 32'hc01b;
        dmem_ready_o = 1'b0;
    end

    // one lfsr bit per cycle decides back-pressure
    always @(posedge clk) begin
        lfsr         <= lfsr_next(lfsr);
        dmem_ready_o <= lfsr[0];
        if (rst_n && dmem_valid_i && dmem_ready_o && dmem_req_i.we) begin
            dmem[dmem_req_i.addr[11:2]] <= dmem_req_i.wdata;
        end
    end

    assign imem_data_o  = imem[imem_addr_i[12:2]];
    assign dmem_rdata_o = dmem[dmem_req_i.addr[11:2]]; // read data in the transfer cycle

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t exit_addr = 'h1000,
    parameter rv_pkg::word_t reset_pc  = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    output rv_pkg::word_t     imem_addr_o,
    input  rv_pkg::word_t     imem_data_i,
    output logic              dmem_valid_o,
    output rv_pkg::dmem_req_t dmem_req_o,
    input  logic              dmem_ready_i,
    input  rv_pkg::word_t     dmem_rdata_i,
    output logic              exit_o,
    output rv_pkg::word_t     gp_o
);
    import rv_pkg::*;

    ctrl_t ctrl;
    word_t imm;
    word_t pc;
    word_t next_pc;
    word_t alu;
    word_t rs1_data;
    word_t rs2_data;
    word_t wb_data;
    logic  exec;
    logic  retire;
    logic  rf_wen;

    assign imem_addr_o = pc;

    rv_pc_control #(
        .exit_addr(exit_addr),
        .reset_pc (reset_pc)
    ) i_rv_pc_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire_i (retire),
        .next_pc_i(next_pc),
        .pc_o     (pc),
        .exec_o   (exec),
        .exit_o   (exit_o)
    );

    rv_decode i_rv_decode (
        .inst_i(imem_data_i), // word held steady while pc does not move
        .exec_i(exec),
        .ctrl_o(ctrl),
        .imm_o (imm)
    );

    rv_regfile i_rv_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_i     (ctrl.rs1),
        .rs2_i     (ctrl.rs2),
        .rd_i      (ctrl.rd),
        .wen_i     (rf_wen),
        .wdata_i   (wb_data),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .gp_o      (gp_o)
    );

    rv_execute i_rv_execute (
        .ctrl_i    (ctrl),
        .imm_i     (imm),
        .pc_i      (pc),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .alu_o     (alu),
        .next_pc_o (next_pc)
    );

    rv_result i_rv_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .exec_i      (exec),
        .ctrl_i      (ctrl),
        .alu_i       (alu),
        .pc_i        (pc),
        .rs2_data_i  (rs2_data),
        .dmem_valid_o(dmem_valid_o),
        .dmem_req_o  (dmem_req_o),
        .dmem_ready_i(dmem_ready_i),
        .dmem_rdata_i(dmem_rdata_i),
        .retire_o    (retire),
        .rf_wen_o    (rf_wen),
        .wb_data_o   (wb_data)
    );

endmodule

`default_nettype wire

//--- rv_pc_control.sv
`default_nettype none

module rv_pc_control #(
    parameter rv_pkg::word_t exit_addr = 'h1000,
    parameter rv_pkg::word_t reset_pc  = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          retire_i,
    input  rv_pkg::word_t next_pc_i,
    output rv_pkg::word_t pc_o,
    output logic          exec_o,
    output logic          exit_o
);
    import rv_pkg::*;

    word_t pc_q;
    logic  exec_q; // 0 fetch, 1 execute

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q   <= reset_pc;
            exec_q <= 1'b0;
        end else if (!exec_q) begin
            exec_q <= !exit_o; // parked in fetch once exit is reached
        end else if (retire_i) begin
            pc_q   <= next_pc_i;
            exec_q <= 1'b0;
        end
    end

    assign pc_o   = pc_q;
    assign exec_o = exec_q;
    assign exit_o = pc_q == exit_addr;

    // fetch address must stay word aligned
    assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00)
        else $error("misaligned pc %h", pc_q);

endmodule

`default_nettype wire

//--- rv_result.sv
`default_nettype none

module rv_result (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              exec_i,
    input  rv_pkg::ctrl_t     ctrl_i,
    input  rv_pkg::word_t     alu_i,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::word_t     rs2_data_i,
    output logic              dmem_valid_o,
    output rv_pkg::dmem_req_t dmem_req_o,
    input  logic              dmem_ready_i,
    input  rv_pkg::word_t     dmem_rdata_i,
    output logic              retire_o,
    output logic              rf_wen_o,
    output rv_pkg::word_t     wb_data_o
);
    import rv_pkg::*;

    logic mem_access;

    assign mem_access   = ctrl_i.mem_rd | ctrl_i.mem_wr;
    assign dmem_valid_o = exec_i & mem_access;

    always_comb begin
        dmem_req_o.addr  = alu_i;
        dmem_req_o.wdata = rs2_data_i;
        dmem_req_o.we    = ctrl_i.mem_wr;
    end

    // memory ops wait for the handshake
    assign retire_o = exec_i & (~mem_access | dmem_ready_i);
    assign rf_wen_o = retire_o & ctrl_i.rf_wen;

    always_comb begin
        case (ctrl_i.wb_sel)
            wb_mem:      wb_data_o = dmem_rdata_i; // valid in the transfer cycle
            wb_pc_plus4: wb_data_o = pc_i + word_t'(4);
            default:     wb_data_o = alu_i;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid_o && !dmem_ready_i |=> dmem_valid_o && $stable(dmem_req_o))
        else $error("data request dropped or changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid_o |-> dmem_req_o.addr[1:0] == 2'b00)
        else $error("misaligned data access at %h", dmem_req_o.addr);

endmodule

`default_nettype wire

//--- rv_execute.sv
`default_nettype none

module rv_execute (
    input  rv_pkg::ctrl_t ctrl_i,
    input  rv_pkg::word_t imm_i,
    input  rv_pkg::word_t pc_i,
    input  rv_pkg::word_t rs1_data_i,
    input  rv_pkg::word_t rs2_data_i,
    output rv_pkg::word_t alu_o,
    output rv_pkg::word_t next_pc_o
);
    import rv_pkg::*;

    word_t op1;
    word_t op2;
    word_t sum;
    logic  br_taken;

    always_comb begin
        case (ctrl_i.op1_sel)
            op1_rs1: op1 = rs1_data_i;
            op1_pc:  op1 = pc_i;
            default: op1 = '0;
        endcase
    end

    assign op2 = ctrl_i.op2_is_imm ? imm_i : rs2_data_i;
    assign sum = op1 + op2;

    always_comb begin
        case (ctrl_i.alu_op)
            alu_add:      alu_o = sum;
            alu_sub:      alu_o = op1 - op2;
            alu_and:      alu_o = op1 & op2;
            alu_or:       alu_o = op1 | op2;
            alu_xor:      alu_o = op1 ^ op2;
            alu_sll:      alu_o = op1 << op2[4:0];
            alu_srl:      alu_o = op1 >> op2[4:0];
            alu_sra:      alu_o = word_t'($signed(op1) >>> op2[4:0]);
            alu_slt:      alu_o = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
            alu_sltu:     alu_o = {{(xlen-1){1'b0}}, op1 < op2};
            alu_jalr_add: alu_o = {sum[xlen-1:1], 1'b0};
            default:      alu_o = op2; // lui
        endcase
    end

    always_comb begin
        case (ctrl_i.br_op)
            br_eq:   br_taken = rs1_data_i == rs2_data_i;
            br_ne:   br_taken = rs1_data_i != rs2_data_i;
            br_lt:   br_taken = $signed(rs1_data_i) < $signed(rs2_data_i);
            br_ge:   br_taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
            br_ltu:  br_taken = rs1_data_i < rs2_data_i;
            br_geu:  br_taken = rs1_data_i >= rs2_data_i;
            default: br_taken = 1'b0;
        endcase
    end

    // jump targets come out of the alu
    assign next_pc_o = br_taken       ? pc_i + imm_i :
                       ctrl_i.is_jump ? alu_o :
                                        pc_i + word_t'(4);

endmodule

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  logic              wen_i,
    input  rv_pkg::word_t     wdata_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o,
    output rv_pkg::word_t     gp_o
);
    import rv_pkg::*;

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wen_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    assign gp_o       = regs[3];

    // each retire is followed by a fetch cycle
    assert property (@(posedge clk) disable iff (!rst_n) wen_i |=> !wen_i)
        else $error("register write outside a single retire cycle");

endmodule

`default_nettype wire

//--- rv_decode.sv
`default_nettype none

module rv_decode (
    input  rv_pkg::inst_u inst_i,
    input  logic          exec_i,
    output rv_pkg::ctrl_t ctrl_o,
    output rv_pkg::word_t imm_o
);
    import rv_pkg::*;

    word_t i_imm;
    word_t s_imm;
    word_t b_imm;
    word_t j_imm;
    word_t u_imm;
    logic  illegal;

    // shared by op and op_imm, alt picks sub / sra
    function automatic alu_op_e alu_func(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  alu_func = alt ? alu_sub : alu_add;
            3'b001:  alu_func = alu_sll;
            3'b010:  alu_func = alu_slt;
            3'b011:  alu_func = alu_sltu;
            3'b100:  alu_func = alu_xor;
            3'b101:  alu_func = alt ? alu_sra : alu_srl;
            3'b110:  alu_func = alu_or;
            default: alu_func = alu_and;
        endcase
    endfunction

    assign i_imm = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
    assign s_imm = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
    assign b_imm = {{20{inst_i.b.imm_12}}, inst_i.b.imm_11, inst_i.b.imm_10_5,
                    inst_i.b.imm_4_1, 1'b0};
    assign j_imm = {{12{inst_i.j.imm_20}}, inst_i.j.imm_19_12, inst_i.j.imm_11,
                    inst_i.j.imm_10_1, 1'b0};
    assign u_imm = {inst_i.u.imm, 12'b0};

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.alu_op  = alu_pass_b;
        ctrl_o.br_op   = br_none;
        ctrl_o.op1_sel = op1_zero;
        ctrl_o.wb_sel  = wb_alu;
        ctrl_o.rd      = inst_i.r.rd;
        ctrl_o.rs1     = inst_i.r.rs1;
        ctrl_o.rs2     = inst_i.r.rs2;
        imm_o          = '0;
        illegal        = 1'b0;
        case (inst_i.r.opcode)
            opc_op: begin
                ctrl_o.alu_op  = alu_func(inst_i.r.funct3, inst_i.r.funct7[5]);
                ctrl_o.op1_sel = op1_rs1;
                ctrl_o.rf_wen  = 1'b1;
            end
            opc_op_imm: begin
                // bit 30 only matters for srai
                ctrl_o.alu_op     = alu_func(inst_i.i.funct3,
                                             inst_i.i.funct3 == 3'b101 && inst_i.r.funct7[5]);
                ctrl_o.op1_sel    = op1_rs1;
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.rf_wen     = 1'b1;
                imm_o             = i_imm;
            end
            opc_load: begin
                ctrl_o.alu_op     = alu_add;
                ctrl_o.op1_sel    = op1_rs1;
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.rf_wen     = inst_i.i.funct3 == 3'b010;
                ctrl_o.mem_rd     = inst_i.i.funct3 == 3'b010; // lw only
                ctrl_o.wb_sel     = wb_mem;
                imm_o             = i_imm;
                illegal           = inst_i.i.funct3 != 3'b010;
            end
            opc_store: begin
                ctrl_o.alu_op     = alu_add;
                ctrl_o.op1_sel    = op1_rs1;
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.mem_wr     = inst_i.s.funct3 == 3'b010; // sw only
                imm_o             = s_imm;
                illegal           = inst_i.s.funct3 != 3'b010;
            end
            opc_branch: begin
                case (inst_i.b.funct3)
                    3'b000:  ctrl_o.br_op = br_eq;
                    3'b001:  ctrl_o.br_op = br_ne;
                    3'b100:  ctrl_o.br_op = br_lt;
                    3'b101:  ctrl_o.br_op = br_ge;
                    3'b110:  ctrl_o.br_op = br_ltu;
                    3'b111:  ctrl_o.br_op = br_geu;
                    default: illegal      = 1'b1;
                endcase
                imm_o = b_imm;
            end
            opc_jal: begin
                ctrl_o.alu_op     = alu_add;
                ctrl_o.op1_sel    = op1_pc;
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.rf_wen     = 1'b1;
                ctrl_o.wb_sel     = wb_pc_plus4;
                ctrl_o.is_jump    = 1'b1;
                imm_o             = j_imm;
            end
            opc_jalr: begin
                ctrl_o.alu_op     = alu_jalr_add;
                ctrl_o.op1_sel    = op1_rs1;
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.rf_wen     = 1'b1;
                ctrl_o.wb_sel     = wb_pc_plus4;
                ctrl_o.is_jump    = 1'b1;
                imm_o             = i_imm;
            end
            opc_lui: begin
                ctrl_o.op2_is_imm = 1'b1; // pass_b of the u immediate
                ctrl_o.rf_wen     = 1'b1;
                imm_o             = u_imm;
            end
            opc_auipc: begin
                ctrl_o.alu_op     = alu_add;
                ctrl_o.op1_sel    = op1_pc;
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.rf_wen     = 1'b1;
                imm_o             = u_imm;
            end
            default: illegal = 1'b1;
        endcase
    end

    // fetch phase may show any word, only the held instruction counts
    always_comb begin
        if (exec_i) begin
            assert (!illegal)
                else $error("unsupported instruction %h executed", inst_i);
        end
    end

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra,
        alu_slt, alu_sltu, alu_jalr_add, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
    } br_op_e;

    typedef enum logic [1:0] {op1_rs1, op1_pc, op1_zero} op1_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4} wb_sel_e;

    // field layouts of one instruction word
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        alu_op_e   alu_op;
        br_op_e    br_op;
        op1_sel_e  op1_sel;
        logic      op2_is_imm;
        logic      rf_wen;
        logic      mem_rd;
        logic      mem_wr;
        wb_sel_e   wb_sel;
        logic      is_jump;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

endpackage

`default_nettype wire
